// File: twdl_pkg.sv
`default_nettype none

package twdl_pkg;

	// sample and twiddle formats
	localparam int w_data = 18;
	localparam int w_twdl = 16;
	localparam int w_phase = 16;
	localparam int n_lanes = 5;

	// one complex sample, Q1.17 per component
	typedef struct packed {
		logic signed [w_data-1:0] re;
		logic signed [w_data-1:0] im;
	} cplx_t;

	typedef cplx_t [n_lanes-1:0] lane_vec_t;

	// radix code, 2 to 5
	typedef logic [2:0] factor_t;

	// rotation engine
	localparam int cordic_iter = 14;
	// 16384 / 1.647
	localparam int cordic_x0 = 9948;

	// atan(2^-i) scaled to 65536 per turn
	localparam logic signed [w_phase-1:0] atan_tab [0:cordic_iter-1] = '{
		16'sd8192,
		16'sd4836,
		16'sd2555,
		16'sd1297,
		16'sd651,
		16'sd326,
		16'sd163,
		16'sd81,
		16'sd41,
		16'sd20,
		16'sd10,
		16'sd5,
		16'sd3,
		16'sd1
	};

	// pipeline depths
	localparam int lat_cordic = 15;
	localparam int lat_powers = 4;
	localparam int lat_mult = 3;
	localparam int lat_total = lat_cordic + lat_powers + lat_mult;

endpackage

`default_nettype wire

// File: twdl_cordic.sv
`timescale 1ns/1ps
`default_nettype none

module twdl_cordic #(
	parameter int w_phase = twdl_pkg::w_phase,
	parameter int w_twdl = twdl_pkg::w_twdl
) (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire        [w_phase-1:0] phase,
	output logic signed [w_twdl-1:0] tw_re,
	output logic signed [w_twdl-1:0] tw_im
);

	import twdl_pkg::*;

	// two guard bits for the gain growth inside the iterations
	localparam int w_cw = w_twdl + 2;
	localparam logic signed [w_cw-1:0] x_start = w_cw'(cordic_x0);

	// stage 0 holds the folded input and stage i+1 the result of iteration i
	logic signed [w_cw-1:0]    x_q [0:cordic_iter];
	logic signed [w_cw-1:0]    y_q [0:cordic_iter];
	// residual angle that steers iteration i
	logic signed [w_phase-1:0] z_q [0:cordic_iter-1];

	// quadrant fold of the start vector
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			x_q[0] <= '0;
			y_q[0] <= '0;
			z_q[0] <= '0;
		end else begin
			case (phase[w_phase-1 -: 2])
				2'd0: begin
					x_q[0] <= x_start;
					y_q[0] <= '0;
				end
				2'd1: begin
					x_q[0] <= '0;
					y_q[0] <= x_start;
				end
				2'd2: begin
					x_q[0] <= -x_start;
					y_q[0] <= '0;
				end
				default: begin
					x_q[0] <= '0;
					y_q[0] <= -x_start;
				end
			endcase
			// residual of 0 to 90 degrees that iteration 0 recentres
			z_q[0] <= {2'b00, phase[w_phase-3:0]};
		end
	end

	// shift-add rotations with one register per iteration
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < cordic_iter; i++) begin
				x_q[i+1] <= '0;
				y_q[i+1] <= '0;
			end
			for (int i = 1; i < cordic_iter; i++) begin
				z_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < cordic_iter; i++) begin
				if (!z_q[i][w_phase-1]) begin
					x_q[i+1] <= x_q[i] - (y_q[i] >>> i);
					y_q[i+1] <= y_q[i] + (x_q[i] >>> i);
				end else begin
					x_q[i+1] <= x_q[i] + (y_q[i] >>> i);
					y_q[i+1] <= y_q[i] - (x_q[i] >>> i);
				end
			end
			// the last iteration leaves no residual behind
			for (int i = 0; i < cordic_iter - 1; i++) begin
				if (!z_q[i][w_phase-1]) begin
					z_q[i+1] <= z_q[i] - atan_tab[i];
				end else begin
					z_q[i+1] <= z_q[i] + atan_tab[i];
				end
			end
		end
	end

	// magnitude stays near 16384 so the guard bits are dropped
	assign tw_re = x_q[cordic_iter][w_twdl-1:0];
	assign tw_im = y_q[cordic_iter][w_twdl-1:0];

endmodule

`default_nettype wire

// File: align_delay.sv
`timescale 1ns/1ps
`default_nettype none

module align_delay #(
	parameter type payload_t = logic,
	parameter int depth = 1,
	parameter int tap_stage = depth
) (
	input  wire      clk,
	input  wire      rst_n,
	input  wire      payload_t din,
	output payload_t dout,
	output payload_t tap
);

	// stage s holds the input from s cycles ago
	payload_t stage_q [1:depth];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int s = 1; s <= depth; s++) begin
				stage_q[s] <= '0;
			end
		end else begin
			stage_q[1] <= din;
			for (int s = 2; s <= depth; s++) begin
				stage_q[s] <= stage_q[s-1];
			end
		end
	end

	assign dout = stage_q[depth];
	// intermediate stage for early consumers
	assign tap = stage_q[tap_stage];

endmodule

`default_nettype wire

// File: twdl_powers.sv
`timescale 1ns/1ps
`default_nettype none

module twdl_powers (
	input  wire                                    clk,
	input  wire                                    inverse,
	input  wire  signed [twdl_pkg::w_twdl-1:0]     tw_re,
	input  wire  signed [twdl_pkg::w_twdl-1:0]     tw_im,
	output logic signed [4:1][twdl_pkg::w_twdl-1:0] tw_re_vec,
	output logic signed [4:1][twdl_pkg::w_twdl-1:0] tw_im_vec
);

	import twdl_pkg::*;

	localparam int w_sq = 2 * w_twdl;
	// Q2.14 times Q2.14 gives 28 fraction bits
	localparam int frac = w_twdl - 2;

	// stage 1, W after conjugation
	logic signed [w_twdl-1:0] r1_q;
	logic signed [w_twdl-1:0] i1_q;

	// stage 2, squaring products
	logic signed [w_sq-1:0]   sq_rr;
	logic signed [w_sq-1:0]   sq_ii;
	logic signed [w_sq-1:0]   sq_ri;
	logic signed [w_twdl-1:0] r1_d2;
	logic signed [w_twdl-1:0] i1_d2;
	logic signed [w_sq-1:0]   sq_re;

	// stage 3, W^2 and W again
	logic signed [w_twdl-1:0] r2_q;
	logic signed [w_twdl-1:0] i2_q;
	logic signed [w_twdl-1:0] r1_d3;
	logic signed [w_twdl-1:0] i1_d3;

	// second rank, W^3 and W^4 before slicing
	logic signed [w_sq-1:0] cu_re;
	logic signed [w_sq-1:0] cu_im;
	logic signed [w_sq-1:0] qu_re;
	logic signed [w_sq-1:0] qu_im;

	// inverse transform uses the conjugate twiddle
	always_ff @(posedge clk) begin
		r1_q <= tw_re;
		i1_q <= inverse ? -tw_im : tw_im;
	end

	always_ff @(posedge clk) begin
		sq_rr <= r1_q * r1_q;
		sq_ii <= i1_q * i1_q;
		sq_ri <= r1_q * i1_q;
		r1_d2 <= r1_q;
		i1_d2 <= i1_q;
	end

	assign sq_re = sq_rr - sq_ii;

	// imag of a square is 2ri, hence the slice one bit lower
	always_ff @(posedge clk) begin
		r2_q  <= sq_re[frac+w_twdl-1:frac];
		i2_q  <= sq_ri[frac+w_twdl-2:frac-1];
		r1_d3 <= r1_d2;
		i1_d3 <= i1_d2;
	end

	assign cu_re = r1_d3 * r2_q - i1_d3 * i2_q;
	assign cu_im = r1_d3 * i2_q + i1_d3 * r2_q;
	assign qu_re = r2_q * r2_q - i2_q * i2_q;
	assign qu_im = r2_q * i2_q;

	// all four powers leave together
	always_ff @(posedge clk) begin
		tw_re_vec[1] <= r1_d3;
		tw_im_vec[1] <= i1_d3;
		tw_re_vec[2] <= r2_q;
		tw_im_vec[2] <= i2_q;
		tw_re_vec[3] <= cu_re[frac+w_twdl-1:frac];
		tw_im_vec[3] <= cu_im[frac+w_twdl-1:frac];
		tw_re_vec[4] <= qu_re[frac+w_twdl-1:frac];
		tw_im_vec[4] <= qu_im[frac+w_twdl-2:frac-1];
	end

endmodule

`default_nettype wire

// File: twdl_mult.sv
`timescale 1ns/1ps
`default_nettype none

module twdl_mult (
	input  wire                                   clk,
	input  wire                                   rst_n,
	input  wire  twdl_pkg::factor_t               factor,
	input  wire                                   val,
	input  wire  twdl_pkg::lane_vec_t             din,
	input  wire signed [4:1][twdl_pkg::w_twdl-1:0] tw_re_vec,
	input  wire signed [4:1][twdl_pkg::w_twdl-1:0] tw_im_vec,
	output twdl_pkg::lane_vec_t                   dout
);

	import twdl_pkg::*;

	// Q1.17 times Q2.14
	localparam int w_prod = w_data + w_twdl;
	localparam int frac = w_twdl - 2;

	// input register
	logic signed [w_data-1:0] d_re_q [0:n_lanes-1];
	logic signed [w_data-1:0] d_im_q [0:n_lanes-1];
	logic signed [w_twdl-1:0] t_re_q [1:n_lanes-1];
	logic signed [w_twdl-1:0] t_im_q [1:n_lanes-1];
	logic                     val_q1;

	// product register
	logic signed [w_prod-1:0] p_rr [1:n_lanes-1];
	logic signed [w_prod-1:0] p_ii [1:n_lanes-1];
	logic signed [w_prod-1:0] p_ri [1:n_lanes-1];
	logic signed [w_prod-1:0] p_ir [1:n_lanes-1];
	cplx_t                    lane0_q;
	logic                     val_q2;

	// sums and rounded results
	logic signed [w_prod-1:0] s_re [1:n_lanes-1];
	logic signed [w_prod-1:0] s_im [1:n_lanes-1];
	logic signed [w_data-1:0] r_re [1:n_lanes-1];
	logic signed [w_data-1:0] r_im [1:n_lanes-1];

	always_ff @(posedge clk) begin
		for (int k = 0; k < n_lanes; k++) begin
			d_re_q[k] <= din[k].re;
			d_im_q[k] <= din[k].im;
		end
		for (int k = 1; k < n_lanes; k++) begin
			t_re_q[k] <= tw_re_vec[k];
			t_im_q[k] <= tw_im_vec[k];
		end
	end

	always_ff @(posedge clk) begin
		for (int k = 1; k < n_lanes; k++) begin
			p_rr[k] <= d_re_q[k] * t_re_q[k];
			p_ii[k] <= d_im_q[k] * t_im_q[k];
			p_ri[k] <= d_re_q[k] * t_im_q[k];
			p_ir[k] <= d_im_q[k] * t_re_q[k];
		end
		// lane 0 has twiddle one
		lane0_q.re <= d_re_q[0];
		lane0_q.im <= d_im_q[0];
	end

	// back to Q1.17, round half up on bit 13
	always_comb begin
		for (int k = 1; k < n_lanes; k++) begin
			s_re[k] = p_rr[k] - p_ii[k];
			s_im[k] = p_ri[k] + p_ir[k];
			r_re[k] = s_re[k][frac+w_data-1:frac] + s_re[k][frac-1];
			r_im[k] = s_im[k][frac+w_data-1:frac] + s_im[k][frac-1];
		end
	end

	// valid follows the data through the first two stages
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			val_q1 <= 1'b0;
			val_q2 <= 1'b0;
		end else begin
			val_q1 <= val;
			val_q2 <= val_q1;
		end
	end

	// lanes at or above the radix and idle beats are zero
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dout <= '0;
		end else begin
			dout <= '0;
			if (val_q2) begin
				dout[0] <= lane0_q;
				for (int k = 1; k < n_lanes; k++) begin
					if (k < factor) begin
						dout[k].re <= r_re[k];
						dout[k].im <= r_im[k];
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: twdl_stage.sv
`timescale 1ns/1ps
`default_nettype none

module twdl_stage (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire twdl_pkg::factor_t       factor,
	input  wire                          inverse,
	input  wire                          in_val,
	input  wire [twdl_pkg::w_phase-1:0]  phase,
	input  wire twdl_pkg::lane_vec_t     din,
	output logic                         out_val,
	output twdl_pkg::lane_vec_t          dout
);

	import twdl_pkg::*;

	// base twiddle from the producer
	logic signed [w_twdl-1:0] tw_re;
	logic signed [w_twdl-1:0] tw_im;

	// powers 1 to 4 for the multipliers
	logic signed [4:1][w_twdl-1:0] tw_re_vec;
	logic signed [4:1][w_twdl-1:0] tw_im_vec;

	// samples and valid lined up with the powers
	lane_vec_t din_dly;
	logic      val_tap;

	twdl_cordic #(
		.w_phase (w_phase),
		.w_twdl  (w_twdl)
	) u_cordic (
		.clk   (clk),
		.rst_n (rst_n),
		.phase (phase),
		.tw_re (tw_re),
		.tw_im (tw_im)
	);

	twdl_powers u_powers (
		.clk       (clk),
		.inverse   (inverse),
		.tw_re     (tw_re),
		.tw_im     (tw_im),
		.tw_re_vec (tw_re_vec),
		.tw_im_vec (tw_im_vec)
	);

	align_delay #(
		.payload_t (lane_vec_t),
		.depth     (lat_cordic + lat_powers)
	) data_dly (
		.clk   (clk),
		.rst_n (rst_n),
		.din   (din),
		.dout  (din_dly),
		.tap   ()
	);

	// the tap feeds the multiplier, the end is the output valid
	align_delay #(
		.payload_t (logic),
		.depth     (lat_total),
		.tap_stage (lat_cordic + lat_powers)
	) val_dly (
		.clk   (clk),
		.rst_n (rst_n),
		.din   (in_val),
		.dout  (out_val),
		.tap   (val_tap)
	);

	twdl_mult u_mult (
		.clk       (clk),
		.rst_n     (rst_n),
		.factor    (factor),
		.val       (val_tap),
		.din       (din_dly),
		.tw_re_vec (tw_re_vec),
		.tw_im_vec (tw_im_vec),
		.dout      (dout)
	);

endmodule

`default_nettype wire

// File: twdl_props.sv
`timescale 1ns/1ps
`default_nettype none

module twdl_props (
	input wire                      clk,
	input wire                      rst_n,
	input wire twdl_pkg::factor_t   factor,
	input wire                      val,
	input wire twdl_pkg::lane_vec_t dout
);

	import twdl_pkg::*;

	// an idle beat at the input leaves as an all-zero vector
	idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
		!val |-> ##3 (dout == '0))
		else $error("dout not zero three cycles after an idle beat");

	// lanes at or above the radix never carry data
	for (genvar k = 1; k < n_lanes; k++) begin : g_mask
		mask_zero: assert property (@(posedge clk) disable iff (!rst_n)
			(k >= factor) |-> (dout[k] == '0))
			else $error("lane %0d not zero with factor %0d", k, factor);
	end

endmodule

bind twdl_mult twdl_props props_i (
	.clk    (clk),
	.rst_n  (rst_n),
	.factor (factor),
	.val    (val),
	.dout   (dout)
);

`default_nettype wire

// File: tb_twdl_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_twdl_stage;

	import twdl_pkg::*;

	localparam int n_reset = 2;
	localparam int n_radix4 = 64;
	localparam int n_mixed = 48;
	localparam int n_gaps = 64;
	localparam int n_edges = 24;
	localparam int n_drain = lat_total + 4;
	// beats, six drains, the last flight and some slack
	localparam int max_cycles = n_reset + 1 + n_radix4 + 2 * n_mixed + n_gaps + n_edges
		+ 6 * n_drain + lat_total + 40;

	logic               clk;
	logic               rst_n;
	factor_t            factor;
	logic               inverse;
	logic               in_val;
	logic [w_phase-1:0] phase;
	lane_vec_t          din;
	logic               out_val;
	lane_vec_t          dout;

	integer seed;
	int     cycle = 0;
	int     n_checks = 0;
	int     val_errs = 0;
	int     data_errs = 0;

	// expected responses, tagged with the cycle they are due
	int        exp_due_q [$];
	logic      exp_val_q [$];
	lane_vec_t exp_dout_q [$];

	twdl_stage dut_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.factor  (factor),
		.inverse (inverse),
		.in_val  (in_val),
		.phase   (phase),
		.din     (din),
		.out_val (out_val),
		.dout    (dout)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= max_cycles) begin
			$display("timeout: run did not finish within %0d cycles", max_cycles);
			$display("Something failed");
			$finish;
		end
	end

	// two's complement wrap to w bits
	function automatic longint sext(longint v, int w);
		int s;
		s = 64 - w;
		return (v <<< s) >>> s;
	endfunction

	function automatic void cordic_model(input logic [w_phase-1:0] ph,
		output longint re, output longint im);
		longint x;
		longint y;
		longint z;
		longint xn;
		case (ph[w_phase-1 -: 2])
			2'd0: begin
				x = cordic_x0;
				y = 0;
			end
			2'd1: begin
				x = 0;
				y = cordic_x0;
			end
			2'd2: begin
				x = -cordic_x0;
				y = 0;
			end
			default: begin
				x = 0;
				y = -cordic_x0;
			end
		endcase
		z = ph[w_phase-3:0];
		for (int i = 0; i < cordic_iter; i++) begin
			if (z >= 0) begin
				xn = x - (y >>> i);
				y = sext(y + (x >>> i), w_twdl + 2);
				z = sext(z - atan_tab[i], w_phase);
			end else begin
				xn = x + (y >>> i);
				y = sext(y - (x >>> i), w_twdl + 2);
				z = sext(z + atan_tab[i], w_phase);
			end
			x = sext(xn, w_twdl + 2);
		end
		re = sext(x, w_twdl);
		im = sext(y, w_twdl);
	endfunction

	// bits 31 to 14 plus the round bit 13
	function automatic logic [w_data-1:0] round_q17(longint s);
		return w_data'((s >>> 14) + ((s >>> 13) & 1));
	endfunction

	function automatic lane_vec_t expect_vec(logic [w_phase-1:0] ph, lane_vec_t d,
		factor_t f, logic inv, logic v);
		lane_vec_t e;
		longint    wr [1:4];
		longint    wi [1:4];
		longint    r1;
		longint    i1;
		longint    s_re;
		longint    s_im;
		e = '0;
		if (!v) begin
			return e;
		end
		cordic_model(ph, r1, i1);
		wr[1] = r1;
		wi[1] = inv ? sext(-i1, w_twdl) : i1;
		wr[2] = sext((wr[1] * wr[1] - wi[1] * wi[1]) >>> 14, w_twdl);
		wi[2] = sext((wr[1] * wi[1]) >>> 13, w_twdl);
		wr[3] = sext((wr[1] * wr[2] - wi[1] * wi[2]) >>> 14, w_twdl);
		wi[3] = sext((wr[1] * wi[2] + wi[1] * wr[2]) >>> 14, w_twdl);
		wr[4] = sext((wr[2] * wr[2] - wi[2] * wi[2]) >>> 14, w_twdl);
		wi[4] = sext((wr[2] * wi[2]) >>> 13, w_twdl);
		e[0] = d[0];
		for (int k = 1; k < n_lanes; k++) begin
			if (k < f) begin
				s_re = longint'(d[k].re) * wr[k] - longint'(d[k].im) * wi[k];
				s_im = longint'(d[k].re) * wi[k] + longint'(d[k].im) * wr[k];
				e[k].re = round_q17(s_re);
				e[k].im = round_q17(s_im);
			end
		end
		return e;
	endfunction

	function automatic lane_vec_t random_vec();
		lane_vec_t v;
		for (int k = 0; k < n_lanes; k++) begin
			v[k].re = w_data'($random(seed));
			v[k].im = w_data'($random(seed));
		end
		return v;
	endfunction

	// every component at the positive or negative limit
	function automatic lane_vec_t full_scale_vec();
		lane_vec_t v;
		for (int k = 0; k < n_lanes; k++) begin
			v[k].re = ($random(seed) & 1) ? 18'sh1ffff : 18'sh20000;
			v[k].im = ($random(seed) & 1) ? 18'sh1ffff : 18'sh20000;
		end
		return v;
	endfunction

	task automatic drive_beat(logic v, logic [w_phase-1:0] ph, lane_vec_t d);
		@(posedge clk);
		#2;
		in_val = v;
		phase = ph;
		din = d;
		exp_due_q.push_back(cycle + lat_total);
		exp_val_q.push_back(v);
		exp_dout_q.push_back(expect_vec(ph, d, factor, inverse, v));
	endtask

	// empty the pipeline before the radix or direction changes
	task automatic set_config(factor_t f, logic inv);
		repeat (n_drain) drive_beat(1'b0, w_phase'($random(seed)), random_vec());
		factor = f;
		inverse = inv;
	endtask

	task automatic run_quadrant_edges();
		logic [w_phase-1:0] ph;
		for (int p = 0; p < 8; p++) begin
			// each edge and the phase just below it
			ph = w_phase'((p >> 1) * 16384 - (p & 1));
			for (int s = 0; s < n_edges / 8; s++) begin
				drive_beat(1'b1, ph, full_scale_vec());
			end
		end
	endtask

	task automatic compare_outputs(logic ev, lane_vec_t ed);
		n_checks++;
		assert (out_val === ev) else begin
			$display("** Error: out_val = %h, expected %h at cycle %0d", out_val, ev, cycle);
			val_errs++;
		end
		for (int k = 0; k < n_lanes; k++) begin
			assert (dout[k] === ed[k]) else begin
				$display("** Error: dout[%0d] = %h, expected %h at cycle %0d",
					k, dout[k], ed[k], cycle);
				data_errs++;
			end
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin : check_blk
		logic      ev;
		lane_vec_t ed;
		ev = 1'b0;
		ed = '0;
		if (exp_due_q.size() > 0 && exp_due_q[0] == cycle) begin
			void'(exp_due_q.pop_front());
			ev = exp_val_q.pop_front();
			ed = exp_dout_q.pop_front();
		end
		compare_outputs(ev, ed);
	end

	initial begin
		seed = 32'h59f73ee8;
		rst_n = 1'b0;
		factor = 3'd4;
		inverse = 1'b0;
		in_val = 1'b0;
		phase = '0;
		din = '0;
		repeat (n_reset) @(posedge clk);
		#2;
		rst_n = 1'b1;

		// radix 4 forward, back to back
		set_config(3'd4, 1'b0);
		repeat (n_radix4) drive_beat(1'b1, w_phase'($random(seed)), random_vec());

		// inverse with radix 5 and radix 3
		set_config(3'd5, 1'b1);
		repeat (n_mixed) drive_beat(1'b1, w_phase'($random(seed)), random_vec());
		set_config(3'd3, 1'b1);
		repeat (n_mixed) drive_beat(1'b1, w_phase'($random(seed)), random_vec());

		// radix 2 with idle beats mixed in
		set_config(3'd2, 1'b0);
		repeat (n_gaps) begin
			drive_beat(($random(seed) & 3) != 0, w_phase'($random(seed)), random_vec());
		end

		set_config(3'd5, 1'b0);
		run_quadrant_edges();

		set_config(3'd5, 1'b0);
		while (exp_due_q.size() > 0) @(negedge clk);
		@(negedge clk);

		$display("checks %0d, out_val errors %0d, dout errors %0d",
			n_checks, val_errs, data_errs);
		if (val_errs + data_errs == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
twdl_pkg.sv
twdl_cordic.sv
align_delay.sv
twdl_powers.sv
twdl_mult.sv
twdl_stage.sv
twdl_props.sv
tb_twdl_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the twiddle stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_twdl_stage \
	-f flist.f -o tb_twdl_stage > build.log 2>&1 \
	&& ./obj_dir/tb_twdl_stage > sim.log 2>&1 \
	|| echo "Something failed" >> sim.log
cat sim.log
# a failed build or an aborted run also counts as a failure
grep -q "Something failed" sim.log && echo "FAIL" && exit 1 || echo "PASS"
